/* dv/tb_clkgen.sv */
// Testbench clock and reset source
// 40 ns clock, active-low reset held for the first five cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic n_rst_o
);

    // Half period of 20 ns
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        n_rst_o = 1'b0;
        repeat (5) @(posedge clk_o);
        n_rst_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tb_vector_load_unit.sv */
// Testbench for the vector load unit
// Preloads memory and runs the load cases of the golden file against the DUT
`timescale 1ns/10ps
`default_nettype none

module tb_vector_load_unit import vload_pkg::*; ();

    logic                    clk_i;
    logic                    n_rst_i;
    logic                    req_valid_i;
    logic                    req_ready_o;
    logic [ADDR_W-1:0]       req_addr_i;
    logic [LEN_W-1:0]        req_len_i;
    logic                    result_valid_o;
    logic                    result_ready_i;
    logic [8*VEC_BYTES-1:0]  result_data_o;
    logic                    mem_we_i;
    logic [MEM_AW-1:0]       mem_waddr_i;
    logic [8*WORD_BYTES-1:0] mem_wdata_i;

    // Golden file contents
    logic [MEM_AW-1:0]       pre_addr_q [$];
    logic [8*WORD_BYTES-1:0] pre_data_q [$];
    string                   case_name_q [$];
    logic [ADDR_W-1:0]       case_addr_q [$];
    logic [LEN_W-1:0]        case_len_q [$];
    logic [8*VEC_BYTES-1:0]  case_exp_q [$];

    tb_clkgen u_clkgen (
        .clk_o   (clk_i),
        .n_rst_o (n_rst_i)
    );

    vector_load_unit dut_i (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_addr_i     (req_addr_i),
        .req_len_i      (req_len_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_data_o  (result_data_o),
        .mem_we_i       (mem_we_i),
        .mem_waddr_i    (mem_waddr_i),
        .mem_wdata_i    (mem_wdata_i)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [8*VEC_BYTES-1:0] expected,
                               input logic [8*VEC_BYTES-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", what, expected, actual));
        end
    endtask

    task automatic read_golden();
        int                      fd;
        int                      code;
        int                      len_val;
        logic [7:0]              tag_v;
        logic [8*32-1:0]         name_v;
        logic [8*256-1:0]        skip_v;
        logic [MEM_AW-1:0]       waddr_v;
        logic [ADDR_W-1:0]       addr_v;
        logic [8*WORD_BYTES-1:0] word_v;
        logic [8*VEC_BYTES-1:0]  exp_v;
        fd = $fopen("dv/vload_golden.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the golden file dv/vload_golden.txt");
        end
        while (1) begin
            tag_v = '0;
            code  = $fscanf(fd, "%s", tag_v);
            if (code != 1) break;
            if (tag_v == "#") begin
                code = $fgets(skip_v, fd);
            end else if (tag_v == "W") begin
                code = $fscanf(fd, "%h %h", waddr_v, word_v);
                if (code != 2) fail_run("A preload line in the golden file is malformed");
                pre_addr_q.push_back(waddr_v);
                pre_data_q.push_back(word_v);
            end else if (tag_v == "C") begin
                name_v = '0;
                code   = $fscanf(fd, "%s %h %d %h", name_v, addr_v, len_val, exp_v);
                if (code != 4) fail_run("A load case line in the golden file is malformed");
                case_name_q.push_back($sformatf("%0s", name_v));
                case_addr_q.push_back(addr_v);
                case_len_q.push_back(LEN_W'(len_val));
                case_exp_q.push_back(exp_v);
            end else begin
                fail_run("The golden file holds a line of unknown type");
            end
        end
        $fclose(fd);
    endtask

    // Runs through reset and the first cycles after it
    task automatic preload_memory();
        for (int i = 0; i < pre_addr_q.size(); i++) begin
            @(posedge clk_i);
            mem_we_i    <= 1'b1;
            mem_waddr_i <= pre_addr_q[i];
            mem_wdata_i <= pre_data_q[i];
        end
        @(posedge clk_i);
        mem_we_i <= 1'b0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!n_rst_i) begin
            if (cycles == 200) begin
                fail_run("Reset was not released within 200 cycles");
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
    endtask

    task automatic send_request(input string name, input logic [ADDR_W-1:0] addr,
                                input logic [LEN_W-1:0] len);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_len_i   <= len;
        @(negedge clk_i);
        while (!req_ready_o) begin
            if (cycles == 200) begin
                fail_run($sformatf("Request of case %s was not accepted in 200 cycles", name));
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        // Accepted here, the write to the top word then stalls the first read
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        mem_we_i    <= 1'b1;
        mem_waddr_i <= MEM_AW'(MEM_WORDS - 1);
        mem_wdata_i <= $urandom;
        @(negedge clk_i);
        check_value($sformatf("%s req_ready_o busy", name), '0, 128'(req_ready_o));
        @(posedge clk_i);
        mem_we_i <= 1'b0;
    endtask

    task automatic collect_result(input string name, input logic [8*VEC_BYTES-1:0] expected);
        int cycles;
        int hold;
        cycles = 0;
        @(negedge clk_i);
        while (!result_valid_o) begin
            if (cycles == 200) begin
                fail_run($sformatf("No result for case %s within 200 cycles", name));
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        hold = int'($urandom % 6);
        for (int i = 0; i <= hold; i++) begin
            check_value($sformatf("%s result_data_o", name), expected, result_data_o);
            check_value($sformatf("%s result_valid_o", name), 128'(1), 128'(result_valid_o));
            check_value($sformatf("%s req_ready_o", name), '0, 128'(req_ready_o));
            if (i < hold) @(negedge clk_i);
        end
        @(posedge clk_i);
        result_ready_i <= 1'b1;
        @(posedge clk_i);
        result_ready_i <= 1'b0;
    endtask

    initial begin
        int seed_val;
        req_valid_i    = 1'b0;
        req_addr_i     = '0;
        req_len_i      = '0;
        result_ready_i = 1'b0;
        mem_we_i       = 1'b0;
        mem_waddr_i    = '0;
        mem_wdata_i    = '0;
        seed_val       = $urandom(32739);

        read_golden();
        if (case_name_q.size() == 0) begin
            fail_run("The golden file holds no load cases");
        end
        preload_memory();
        wait_reset_release();

        check_value("reset req_ready_o", 128'(1), 128'(req_ready_o));
        check_value("reset result_valid_o", '0, 128'(result_valid_o));
        check_value("reset result_data_o", '0, result_data_o);

        for (int c = 0; c < case_name_q.size(); c++) begin
            send_request(case_name_q[c], case_addr_q[c], case_len_q[c]);
            collect_result(case_name_q[c], case_exp_q[c]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/vload_golden.txt */
# W <word address hex> <word data hex>
# C <case name> <byte address hex> <length decimal> <expected 128-bit result hex>
W 00 23222120
W 01 27262524
W 02 2b2a2928
W 03 2f2e2d2c
W 04 33323130
W 05 37363534
W 06 3b3a3938
W 07 3f3e3d3c
W 08 43424140
W 09 47464544
W 0a 4b4a4948
W 0b 4f4e4d4c
W 0c 53525150
W 0d 57565554
W 0e 5b5a5958
W 0f 5f5e5d5c
# Aligned full loads, unaligned ranges and single bytes after full loads
C full_aligned_0 0000 16 2f2e2d2c2b2a29282726252423222120
C unaligned_5_11 0005 11 00000000002f2e2d2c2b2a2928272625
C full_aligned_16 0010 16 3f3e3d3c3b3a39383736353433323130
C short_2_1 0002 1 00000000000000000000000000000022
C unaligned_3_16 0003 16 3231302f2e2d2c2b2a29282726252423
C cross_6_4 0006 4 00000000000000000000000029282726
C tail_61_3 003d 3 000000000000000000000000005f5e5d
C mid_33_9 0021 9 00000000000000494847464544434241
C one_word_8_4 0008 4 0000000000000000000000002b2a2928
C short_15_1 000f 1 0000000000000000000000000000002f
C full_aligned_48 0030 16 5f5e5d5c5b5a59585756555453525150
C unaligned_47_14 002f 14 00005c5b5a595857565554535251504f

/* rtl/temporary_reg.sv */
// Temporary vector register
// Packs the enabled bytes of each read word at the running byte offset
`timescale 1ns/10ps
`default_nettype none

module temporary_reg import vload_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             n_rst_i,
    vload_pack_if.packer          pack,
    output logic [8*VEC_BYTES-1:0] wide_vd_o
);

    logic [WORD_BYTES-1:0] ben_q;
    logic [7:0]            temp_reg [VEC_BYTES];
    logic [7:0]            word_bytes [WORD_BYTES];
    logic [7:0]            pk_bytes [WORD_BYTES];
    logic [2:0]            pk_cnt;

    // Enables are captured with the request, data comes a cycle later
    always_ff @(posedge clk_i, negedge n_rst_i) begin
        if (!n_rst_i) begin
            ben_q <= '0;
        end else if (pack.ben_valid) begin
            ben_q <= pack.ben;
        end
    end

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            word_bytes[i] = pack.data[8*i +: 8];
        end
    end

    // Shift enabled bytes down so they sit without gaps
    always_comb begin
        pk_cnt   = '0;
        pk_bytes = '{default: 8'd0};
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (ben_q[i]) begin
                pk_bytes[pk_cnt[1:0]] = word_bytes[i];
                pk_cnt                = pk_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_i, negedge n_rst_i) begin
        if (!n_rst_i) begin
            temp_reg <= '{default: 8'd0};
        end else if (pack.clear) begin
            temp_reg <= '{default: 8'd0};
        end else if (pack.data_valid) begin
            for (int j = 0; j < WORD_BYTES; j++) begin
                if (j < int'(pk_cnt) && int'(pack.sel) + j < VEC_BYTES) begin
                    temp_reg[int'(pack.sel) + j] <= pk_bytes[j];
                end
            end
        end
    end

    // Byte 15 in the top lane down to byte 0
    always_comb begin
        for (int k = 0; k < VEC_BYTES; k++) begin
            wide_vd_o[8*k +: 8] = temp_reg[k];
        end
    end

endmodule

`default_nettype wire

/* rtl/vector_load_unit.sv */
// Vector load unit top level
// Data memory, load sequencer and temporary register
`timescale 1ns/10ps
`default_nettype none

module vector_load_unit import vload_pkg::*; (
    input  wire logic                    clk_i,
    input  wire logic                    n_rst_i,

    // Load request
    input  wire logic                    req_valid_i,
    output logic                         req_ready_o,
    input  wire logic [ADDR_W-1:0]       req_addr_i,
    input  wire logic [LEN_W-1:0]        req_len_i,

    // Load result
    output logic                         result_valid_o,
    input  wire logic                    result_ready_i,
    output logic [8*VEC_BYTES-1:0]       result_data_o,

    // Memory preload
    input  wire logic                    mem_we_i,
    input  wire logic [MEM_AW-1:0]       mem_waddr_i,
    input  wire logic [8*WORD_BYTES-1:0] mem_wdata_i
);

    vload_mem_if  mem_bus ();
    vload_pack_if pack_bus ();

    word_memory u_mem (
        .clk_i       (clk_i),
        .n_rst_i     (n_rst_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .rd          (mem_bus.responder)
    );

    vload_sequencer u_seq (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_addr_i     (req_addr_i),
        .req_len_i      (req_len_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .mem            (mem_bus.requester),
        .pack           (pack_bus.master)
    );

    temporary_reg u_tmp (
        .clk_i     (clk_i),
        .n_rst_i   (n_rst_i),
        .pack      (pack_bus.packer),
        .wide_vd_o (result_data_o)
    );

endmodule

`default_nettype wire

/* rtl/vload_mem_if.sv */
// Memory read request and registered read response
`timescale 1ns/10ps
`default_nettype none

interface vload_mem_if import vload_pkg::*; ();

    logic                    rd_valid;
    logic [MEM_AW-1:0]       rd_addr;
    logic [WORD_BYTES-1:0]   rd_ben;
    logic                    rd_ready;
    logic                    rsp_valid;
    logic [8*WORD_BYTES-1:0] rsp_data;

    modport requester (
        output rd_valid, rd_addr, rd_ben,
        input  rd_ready, rsp_valid, rsp_data
    );

    // Byte enables are for the packer, the memory reads whole words
    modport responder (
        input  rd_valid, rd_addr,
        output rd_ready, rsp_valid, rsp_data
    );

endinterface

`default_nettype wire

/* rtl/vload_pack_if.sv */
// Sequencer to temporary register control and data
`timescale 1ns/10ps
`default_nettype none

interface vload_pack_if import vload_pkg::*; ();

    logic                    clear;
    logic                    ben_valid;
    logic [WORD_BYTES-1:0]   ben;
    logic                    data_valid;
    logic [8*WORD_BYTES-1:0] data;
    logic [SEL_W-1:0]        sel;

    modport master (
        output clear, ben_valid, ben, data_valid, data, sel
    );

    modport packer (
        input  clear, ben_valid, ben, data_valid, data, sel
    );

endinterface

`default_nettype wire

/* rtl/vload_pkg.sv */
// Shared sizes, memory depth and sequencer state for the vector load unit
`default_nettype none

package vload_pkg;

    // Memory word and result vector sizes in bytes
    localparam int WORD_BYTES = 4;
    localparam int VEC_BYTES  = 16;

    // Request fields
    localparam int ADDR_W = 16;
    localparam int LEN_W  = 5;

    // Data memory geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // Byte offset into the temporary register
    localparam int SEL_W = 7;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_ISSUE,
        LD_WAIT,
        LD_DONE
    } ld_state_e;

endpackage

`default_nettype wire

/* rtl/vload_sequencer.sv */
// Load sequencer FSM
// Walks the words of a byte range, one read in flight, and drives the packer
`timescale 1ns/10ps
`default_nettype none

module vload_sequencer import vload_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              n_rst_i,
    input  wire logic              req_valid_i,
    output logic                   req_ready_o,
    input  wire logic [ADDR_W-1:0] req_addr_i,
    input  wire logic [LEN_W-1:0]  req_len_i,
    output logic                   result_valid_o,
    input  wire logic              result_ready_i,
    vload_mem_if.requester         mem,
    vload_pack_if.master           pack
);

    ld_state_e             state;
    ld_state_e             state_nxt;
    logic [ADDR_W-1:0]     cur_addr;
    logic [LEN_W-1:0]      remain;
    logic [SEL_W-1:0]      sel_q;
    logic [1:0]            byte_lo;
    logic [2:0]            avail;
    logic [2:0]            take;
    logic [WORD_BYTES-1:0] word_ben;
    logic                  last_word;

    // Bytes of the current word inside the range
    assign byte_lo = cur_addr[1:0];
    assign avail   = 3'(WORD_BYTES) - {1'b0, byte_lo};
    assign take    = (remain < {2'b00, avail}) ? remain[2:0] : avail;

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            word_ben[i] = (i >= int'(byte_lo)) && (i < int'(byte_lo) + int'(take));
        end
    end

    assign last_word = (remain == LEN_W'(take));

    always_comb begin
        state_nxt = state;
        case (state)
            LD_IDLE: begin
                if (req_valid_i) begin
                    state_nxt = LD_ISSUE;
                end
            end
            LD_ISSUE: begin
                if (mem.rd_ready) begin
                    state_nxt = LD_WAIT;
                end
            end
            LD_WAIT: begin
                if (mem.rsp_valid) begin
                    state_nxt = last_word ? LD_DONE : LD_ISSUE;
                end
            end
            LD_DONE: begin
                if (result_ready_i) begin
                    state_nxt = LD_IDLE;
                end
            end
            default: state_nxt = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i, negedge n_rst_i) begin
        if (!n_rst_i) begin
            state    <= LD_IDLE;
            cur_addr <= '0;
            remain   <= '0;
            sel_q    <= '0;
        end else begin
            state <= state_nxt;
            if (state == LD_IDLE && req_valid_i) begin
                cur_addr <= req_addr_i;
                remain   <= req_len_i;
                sel_q    <= '0;
            end else if (state == LD_WAIT && mem.rsp_valid) begin
                // Next word starts at its boundary
                sel_q    <= sel_q + SEL_W'(take);
                cur_addr <= {cur_addr[ADDR_W-1:2] + 1'b1, 2'b00};
                remain   <= remain - LEN_W'(take);
            end
        end
    end

    assign req_ready_o    = (state == LD_IDLE);
    assign result_valid_o = (state == LD_DONE);

    // Memory read request
    assign mem.rd_valid = (state == LD_ISSUE);
    assign mem.rd_addr  = cur_addr[MEM_AW+1:2];
    assign mem.rd_ben   = word_ben;

    // Packer control
    assign pack.clear      = req_ready_o & req_valid_i;
    assign pack.ben_valid  = mem.rd_valid & mem.rd_ready;
    assign pack.ben        = mem.rd_ben;
    assign pack.data_valid = (state == LD_WAIT) & mem.rsp_valid;
    assign pack.data       = mem.rsp_data;
    assign pack.sel        = sel_q;

endmodule

`default_nettype wire

/* rtl/word_memory.sv */
// Word-addressed data memory
// Registered read port plus a preload write port that wins over reads
`timescale 1ns/10ps
`default_nettype none

module word_memory import vload_pkg::*; (
    input  wire logic                    clk_i,
    input  wire logic                    n_rst_i,
    input  wire logic                    mem_we_i,
    input  wire logic [MEM_AW-1:0]       mem_waddr_i,
    input  wire logic [8*WORD_BYTES-1:0] mem_wdata_i,
    vload_mem_if.responder               rd
);

    logic [8*WORD_BYTES-1:0] mem_array [MEM_WORDS];
    logic                    rd_accept;

    // A preload write blocks the read for that cycle
    assign rd.rd_ready = ~mem_we_i;
    assign rd_accept   = rd.rd_valid & rd.rd_ready;

    always_ff @(posedge clk_i) begin
        if (mem_we_i) begin
            mem_array[mem_waddr_i] <= mem_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            rd.rsp_data <= mem_array[rd.rd_addr];
        end
    end

    // Response strobe one cycle after acceptance
    always_ff @(posedge clk_i, negedge n_rst_i) begin
        if (!n_rst_i) begin
            rd.rsp_valid <= 1'b0;
        end else begin
            rd.rsp_valid <= rd_accept;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the vector load unit testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed check returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f sources.f --top-module tb_vector_load_unit -Mdir obj_dir \
    && ./obj_dir/Vtb_vector_load_unit \
    || exit 1

/* sources.f */
rtl/vload_pkg.sv
rtl/vload_mem_if.sv
rtl/vload_pack_if.sv
rtl/word_memory.sv
rtl/vload_sequencer.sv
rtl/temporary_reg.sv
rtl/vector_load_unit.sv
dv/tb_clkgen.sv
dv/tb_vector_load_unit.sv
